/* include/dm_cfg.svh */
// data-mover test configuration with bus widths, buffer size and gpio start defaults
`ifndef DM_CFG_SVH
`define DM_CFG_SVH

// word address width on both wishbone ports
`define DM_ADDR_W 32

// data word width, upper half address and lower half its inverse
`define DM_DATA_W 64

// run length in words, up to 511 so a run can overrun the buffer
`define DM_LEN_W 9

// buffer index width, only these low address bits are decoded
`define DM_BUF_AW 8
`define DM_BUF_DEPTH (1 << `DM_BUF_AW)

// run launched by a gpio rising edge
`define DM_GPIO_LEN 128
`define DM_GPIO_ADDR 32'h3000_0000

`endif

/* hw/dm_test_pkg.sv */
// data-mover test control types, fsm states and the expected pattern function
`include "dm_cfg.svh"

package dm_test_pkg;

    // run length in words
    typedef logic [`DM_LEN_W-1:0] dm_len_t;

    // mismatch count, never more than one run length
    typedef logic [`DM_LEN_W-1:0] dm_err_cnt_t;

    // producer fsm
    typedef enum logic [1:0] {
        WR_IDLE,        // waiting for a start edge
        WR_WRITE,       // pattern writes in flight
        WR_WAIT_CHECK   // readback running in the checker
    } wr_state_e;

    // consumer fsm
    typedef enum logic {
        RD_IDLE,
        RD_READ
    } rd_state_e;

    // expected word for a word address
    function automatic logic [`DM_DATA_W-1:0] dm_pattern(input logic [`DM_ADDR_W-1:0] adr);
        return {adr, ~adr};
    endfunction

endpackage

/* hw/wb_bus_pkg.sv */
// wishbone classic bus types shared by the buffer ports and their masters
`include "dm_cfg.svh"

package wb_bus_pkg;

    // word address, one step per 64-bit word
    typedef logic [`DM_ADDR_W-1:0] wb_adr_t;

    // data word, full words only so no select lanes
    typedef logic [`DM_DATA_W-1:0] wb_dat_t;

endpackage

/* hw/dm_pattern_writer.sv */
// pattern writer that detects start edges, latches the run and writes the buffer
`timescale 1ns/1ns
`include "dm_cfg.svh"

module dm_pattern_writer (
    input  logic                 i_clk_80,
    input  logic                 i_rst_80,
    input  logic                 i_start,       // host start level
    input  logic                 i_gpio,        // gpio start level
    input  dm_test_pkg::dm_len_t i_length,
    input  wb_bus_pkg::wb_adr_t  i_start_addr,
    input  logic                 i_wr_ack,
    input  logic                 i_check_done,  // checker finished the readback
    output logic                 o_wr_cyc,
    output logic                 o_wr_stb,
    output wb_bus_pkg::wb_adr_t  o_wr_adr,
    output wb_bus_pkg::wb_dat_t  o_wr_dat,
    output logic                 o_go,          // launches the readback
    output wb_bus_pkg::wb_adr_t  o_run_addr,
    output dm_test_pkg::dm_len_t o_run_len,
    output logic                 o_busy
);
    import dm_test_pkg::*;
    import wb_bus_pkg::*;

    wr_state_e state;
    logic      start_q;     // previous host level
    logic      gpio_q;      // previous gpio level
    logic      host_p;      // registered host edge
    logic      gpio_p;      // registered gpio edge
    logic      start_ok;
    dm_len_t   words_left;
    dm_len_t   new_len;
    wb_adr_t   new_addr;
    wb_adr_t   wr_adr_nxt;

    always_ff @(posedge i_clk_80) begin
        if (i_rst_80) begin
            start_q <= 1'b0;
            gpio_q  <= 1'b0;
            host_p  <= 1'b0;
            gpio_p  <= 1'b0;
        end else begin
            start_q <= i_start;
            gpio_q  <= i_gpio;
            host_p  <= i_start & ~start_q;  // rising edges only
            gpio_p  <= i_gpio & ~gpio_q;
        end
    end

    // busy drops in the same cycle as the checker's done pulse
    assign o_busy   = (state != WR_IDLE) && !((state == WR_WAIT_CHECK) && i_check_done);
    assign start_ok = (host_p | gpio_p) & ~o_busy;     // edges during a run are dropped
    assign new_len  = gpio_p ? dm_len_t'(`DM_GPIO_LEN) : i_length;  // gpio wins on a tie
    assign new_addr = gpio_p ? wb_adr_t'(`DM_GPIO_ADDR) : i_start_addr;
    assign wr_adr_nxt = o_wr_adr + wb_adr_t'(1);

    always_ff @(posedge i_clk_80) begin
        if (i_rst_80) begin
            state      <= WR_IDLE;
            o_wr_cyc   <= 1'b0;
            o_wr_stb   <= 1'b0;
            o_go       <= 1'b0;
            words_left <= '0;
        end else begin
            o_go <= 1'b0;                   // single-cycle pulse
            case (state)
                WR_WRITE: begin
                    if (i_wr_ack) begin
                        if (words_left == dm_len_t'(1)) begin
                            o_wr_cyc <= 1'b0;   // last word acked
                            o_wr_stb <= 1'b0;
                            o_go     <= 1'b1;
                            state    <= WR_WAIT_CHECK;
                        end else begin
                            words_left <= words_left - dm_len_t'(1);
                        end
                    end
                end
                WR_WAIT_CHECK: begin
                    if (i_check_done) begin
                        state <= WR_IDLE;
                    end
                end
                default: begin
                end
            endcase
            if (start_ok) begin
                words_left <= new_len;
                if (new_len == '0) begin
                    o_go  <= 1'b1;          // nothing to write, straight to readback
                    state <= WR_WAIT_CHECK;
                end else begin
                    o_wr_cyc <= 1'b1;
                    o_wr_stb <= 1'b1;
                    state    <= WR_WRITE;
                end
            end
        end
    end

    // run parameters and bus payload
    always_ff @(posedge i_clk_80) begin
        if (start_ok) begin
            o_run_addr <= new_addr;
            o_run_len  <= new_len;
            o_wr_adr   <= new_addr;
            o_wr_dat   <= dm_pattern(new_addr);
        end else if ((state == WR_WRITE) && i_wr_ack) begin
            o_wr_adr <= wr_adr_nxt;         // next word presented right after ack
            o_wr_dat <= dm_pattern(wr_adr_nxt);
        end
    end

    a_stb_in_cyc: assert property (@(posedge i_clk_80) disable iff (i_rst_80)
        o_wr_stb |-> o_wr_cyc);

    // address held until the buffer acks
    a_adr_hold: assert property (@(posedge i_clk_80) disable iff (i_rst_80)
        (o_wr_stb && !i_wr_ack) |=> $stable(o_wr_adr));

endmodule

/* hw/dm_mem_buffer.sv */
// 256-word buffer standing in for ddr with a wishbone write port and a read port
`timescale 1ns/1ns
`include "dm_cfg.svh"

module dm_mem_buffer (
    input  logic                i_clk_80,
    input  logic                i_rst_80,
    input  logic                i_wr_cyc,
    input  logic                i_wr_stb,
    input  wb_bus_pkg::wb_adr_t i_wr_adr,
    input  wb_bus_pkg::wb_dat_t i_wr_dat,
    input  logic                i_rd_cyc,
    input  logic                i_rd_stb,
    input  wb_bus_pkg::wb_adr_t i_rd_adr,
    output logic                o_wr_ack,
    output logic                o_rd_ack,
    output wb_bus_pkg::wb_dat_t o_rd_dat
);
    import wb_bus_pkg::*;

    wb_dat_t mem [0:`DM_BUF_DEPTH-1];   // no reset on the array
    logic    wr_hit;
    logic    rd_hit;

    // a request is taken once, the ack cycle blocks a second take
    assign wr_hit = i_wr_cyc & i_wr_stb & ~o_wr_ack;
    assign rd_hit = i_rd_cyc & i_rd_stb & ~o_rd_ack;

    always_ff @(posedge i_clk_80) begin
        if (i_rst_80) begin
            o_wr_ack <= 1'b0;
            o_rd_ack <= 1'b0;
        end else begin
            o_wr_ack <= wr_hit;     // ack one cycle after stb
            o_rd_ack <= rd_hit;
        end
    end

    always_ff @(posedge i_clk_80) begin
        if (wr_hit) begin
            mem[i_wr_adr[`DM_BUF_AW-1:0]] <= i_wr_dat;  // upper bits alias
        end
        if (rd_hit) begin
            o_rd_dat <= mem[i_rd_adr[`DM_BUF_AW-1:0]];  // valid with the ack
        end
    end

    a_wr_ack_single: assert property (@(posedge i_clk_80) disable iff (i_rst_80)
        o_wr_ack |=> !o_wr_ack);

    a_rd_ack_single: assert property (@(posedge i_clk_80) disable iff (i_rst_80)
        o_rd_ack |=> !o_rd_ack);

endmodule

/* hw/dm_readback_checker.sv */
// readback checker that reads a run back over wishbone and counts pattern mismatches
`timescale 1ns/1ns

module dm_readback_checker (
    input  logic                     i_clk_80,
    input  logic                     i_rst_80,
    input  logic                     i_go,          // writes finished
    input  wb_bus_pkg::wb_adr_t      i_run_addr,
    input  dm_test_pkg::dm_len_t     i_run_len,
    input  logic                     i_rd_ack,
    input  wb_bus_pkg::wb_dat_t      i_rd_dat,
    output logic                     o_rd_cyc,
    output logic                     o_rd_stb,
    output wb_bus_pkg::wb_adr_t      o_rd_adr,
    output logic                     o_done,        // end of the run
    output dm_test_pkg::dm_err_cnt_t o_err_count
);
    import dm_test_pkg::*;
    import wb_bus_pkg::*;

    rd_state_e state;
    dm_len_t   words_left;
    wb_adr_t   rd_adr_nxt;
    logic      mismatch;

    assign rd_adr_nxt = o_rd_adr + wb_adr_t'(1);
    assign mismatch   = (i_rd_dat != dm_pattern(o_rd_adr));   // full address, not the index

    always_ff @(posedge i_clk_80) begin
        if (i_rst_80) begin
            state       <= RD_IDLE;
            o_rd_cyc    <= 1'b0;
            o_rd_stb    <= 1'b0;
            o_done      <= 1'b0;
            o_err_count <= '0;
            words_left  <= '0;
        end else begin
            o_done <= 1'b0;
            case (state)
                RD_IDLE: begin
                    if (i_go) begin
                        o_err_count <= '0;          // fresh count per run
                        words_left  <= i_run_len;
                        if (i_run_len == '0) begin
                            o_done <= 1'b1;         // empty run
                        end else begin
                            o_rd_cyc <= 1'b1;
                            o_rd_stb <= 1'b1;
                            state    <= RD_READ;
                        end
                    end
                end
                RD_READ: begin
                    if (i_rd_ack) begin
                        if (mismatch) begin
                            o_err_count <= o_err_count + dm_err_cnt_t'(1);
                        end
                        if (words_left == dm_len_t'(1)) begin
                            o_rd_cyc <= 1'b0;
                            o_rd_stb <= 1'b0;
                            o_done   <= 1'b1;       // count is final here
                            state    <= RD_IDLE;
                        end else begin
                            words_left <= words_left - dm_len_t'(1);
                        end
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk_80) begin
        if ((state == RD_IDLE) && i_go) begin
            o_rd_adr <= i_run_addr;
        end else if ((state == RD_READ) && i_rd_ack) begin
            o_rd_adr <= rd_adr_nxt;     // step after each ack
        end
    end

    // buffer must only answer an open strobe
    a_ack_needs_stb: assert property (@(posedge i_clk_80) disable iff (i_rst_80)
        i_rd_ack |-> o_rd_stb);

endmodule

/* hw/dm_test_top.sv */
// data-mover validation top joining the pattern writer, buffer and readback checker
`timescale 1ns/1ns

module dm_test_top (
    input  logic                     i_clk_80,
    input  logic                     i_rst_80,
    input  logic                     i_start,
    input  logic                     i_gpio,
    input  dm_test_pkg::dm_len_t     i_length,
    input  wb_bus_pkg::wb_adr_t      i_start_addr,
    output logic                     o_busy,
    output logic                     o_done,
    output dm_test_pkg::dm_err_cnt_t o_err_count
);
    import dm_test_pkg::*;
    import wb_bus_pkg::*;

    // write port
    logic    wr_cyc;
    logic    wr_stb;
    wb_adr_t wr_adr;
    wb_dat_t wr_dat;
    logic    wr_ack;
    // read port
    logic    rd_cyc;
    logic    rd_stb;
    wb_adr_t rd_adr;
    wb_dat_t rd_dat;
    logic    rd_ack;
    // writer to checker handoff
    logic    go;
    wb_adr_t run_addr;
    dm_len_t run_len;

    dm_pattern_writer dm_pattern_writer_i (
        .i_clk_80     (i_clk_80),
        .i_rst_80     (i_rst_80),
        .i_start      (i_start),
        .i_gpio       (i_gpio),
        .i_length     (i_length),
        .i_start_addr (i_start_addr),
        .i_wr_ack     (wr_ack),
        .i_check_done (o_done),     // run ends with the checker
        .o_wr_cyc     (wr_cyc),
        .o_wr_stb     (wr_stb),
        .o_wr_adr     (wr_adr),
        .o_wr_dat     (wr_dat),
        .o_go         (go),
        .o_run_addr   (run_addr),
        .o_run_len    (run_len),
        .o_busy       (o_busy)
    );

    dm_mem_buffer dm_mem_buffer_i (
        .i_clk_80 (i_clk_80),
        .i_rst_80 (i_rst_80),
        .i_wr_cyc (wr_cyc),
        .i_wr_stb (wr_stb),
        .i_wr_adr (wr_adr),
        .i_wr_dat (wr_dat),
        .i_rd_cyc (rd_cyc),
        .i_rd_stb (rd_stb),
        .i_rd_adr (rd_adr),
        .o_wr_ack (wr_ack),
        .o_rd_ack (rd_ack),
        .o_rd_dat (rd_dat)
    );

    dm_readback_checker dm_readback_checker_i (
        .i_clk_80    (i_clk_80),
        .i_rst_80    (i_rst_80),
        .i_go        (go),
        .i_run_addr  (run_addr),
        .i_run_len   (run_len),
        .i_rd_ack    (rd_ack),
        .i_rd_dat    (rd_dat),
        .o_rd_cyc    (rd_cyc),
        .o_rd_stb    (rd_stb),
        .o_rd_adr    (rd_adr),
        .o_done      (o_done),
        .o_err_count (o_err_count)
    );

endmodule

/* dv/dm_test_tb.sv */
// testbench for the data-mover validation top that replays runs from a vector file
`timescale 1ns/1ns
`include "dm_cfg.svh"

module dm_test_tb;
    import dm_test_pkg::*;
    import wb_bus_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 8;

    logic        clk_80;
    logic        rst_80;
    logic        start;
    logic        gpio;
    dm_len_t     length;
    wb_adr_t     start_addr;
    logic        busy;
    logic        done;
    dm_err_cnt_t err_count;

    int          kind_q[$];     // vector columns, one entry per run
    int          len_q[$];
    wb_adr_t     addr_q[$];
    int          errs_q[$];
    int          errors;
    int          checks;
    int          budget;        // watchdog limit in cycles
    logic        budget_ready;
    logic [31:0] rng;
    logic        load_ok;

    dm_test_top dm_test_top_i (
        .i_clk_80     (clk_80),
        .i_rst_80     (rst_80),
        .i_start      (start),
        .i_gpio       (gpio),
        .i_length     (length),
        .i_start_addr (start_addr),
        .o_busy       (busy),
        .o_done       (done),
        .o_err_count  (err_count)
    );

    always #(CLK_PERIOD / 2) clk_80 = ~clk_80;

    function automatic logic [31:0] xorshift_next(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // kinds 1 and 3 raise gpio, which forces the default length
    function automatic int run_length(input int kind, input int len);
        return ((kind == 1) || (kind == 3)) ? `DM_GPIO_LEN : len;
    endfunction

    // words past the buffer depth land on the start of the run
    function automatic dm_err_cnt_t expected_errors(input int len);
        return (len > `DM_BUF_DEPTH) ? dm_err_cnt_t'(len - `DM_BUF_DEPTH) : dm_err_cnt_t'(0);
    endfunction

    task automatic compare_count(input string name, input dm_err_cnt_t got,
                                 input dm_err_cnt_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic load_vectors(output logic ok);
        int      fd;
        int      kind;
        int      len;
        int      errs;
        wb_adr_t addr;
        string   line;
        fd = $fopen("dv/dm_vectors.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "%d %d %h %d", kind, len, addr, errs) == 4) begin  // skips comments
                    kind_q.push_back(kind);
                    len_q.push_back(len);
                    addr_q.push_back(addr);
                    errs_q.push_back(errs);
                    budget += 6 * run_length(kind, len) + 20;
                end
            end
            $fclose(fd);
        end
        ok = ok && (kind_q.size() > 0);
    endtask

    // no activity allowed between runs
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk_80);
            compare_bit("o_busy", busy, 1'b0);
            compare_bit("o_done", done, 1'b0);
        end
    endtask

    task automatic do_run(input int idx);
        int          kind;
        int          eff_len;
        int          cycles;
        int          limit;
        logic        seen;
        dm_err_cnt_t exp_err;
        kind    = kind_q[idx];
        eff_len = run_length(kind, len_q[idx]);
        exp_err = expected_errors(eff_len);
        limit   = 6 * eff_len + 20;
        if (int'(exp_err) != errs_q[idx]) begin
            errors++;
            $display("vector run %0d lists %0d errors but %0d are expected from the length",
                     idx, errs_q[idx], exp_err);
        end
        @(posedge clk_80);
        start      <= (kind != 1);
        gpio       <= (kind == 1) || (kind == 3);  // both together on kind 3
        length     <= dm_len_t'(len_q[idx]);
        start_addr <= addr_q[idx];
        @(posedge clk_80);
        start <= 1'b0;
        gpio  <= 1'b0;
        @(posedge clk_80);                         // edge registered here
        @(negedge clk_80);
        compare_bit("o_busy", busy, 1'b1);
        cycles = 0;
        seen   = 1'b0;
        while (!seen && (cycles < limit)) begin
            @(posedge clk_80);
            if ((kind == 2) && (eff_len > 1) && (cycles == 3 * eff_len)) begin
                start <= 1'b1;                     // extra edge during the readback
            end
            if ((kind == 2) && (eff_len > 1) && (cycles == 3 * eff_len + 1)) begin
                start <= 1'b0;
            end
            @(negedge clk_80);
            if (done) begin
                seen = 1'b1;
                compare_bit("o_busy", busy, 1'b0); // drops with done
                compare_count("o_err_count", err_count, exp_err);
            end else begin
                compare_bit("o_busy", busy, 1'b1);
            end
            cycles++;
        end
        if (!seen) begin
            errors++;
            $display("run %0d gave no o_done within %0d cycles", idx, limit);
        end
        if (kind == 2) begin
            idle_cycles(8);                        // dropped edge must not start a run
        end
    endtask

    initial begin
        clk_80       = 1'b0;
        rst_80       = 1'b1;
        start        = 1'b0;
        gpio         = 1'b0;
        length       = '0;
        start_addr   = '0;
        errors       = 0;
        checks       = 0;
        budget       = RST_CYCLES;
        budget_ready = 1'b0;
        rng          = 32'h6a6d3259;
        load_vectors(load_ok);
        if (load_ok) begin
            budget_ready = 1'b1;
            repeat (RST_CYCLES) @(posedge clk_80);
            rst_80 <= 1'b0;
            @(negedge clk_80);
            compare_bit("o_busy", busy, 1'b0);
            compare_bit("o_done", done, 1'b0);
            compare_count("o_err_count", err_count, dm_err_cnt_t'(0));
            foreach (kind_q[i]) begin
                rng = xorshift_next(rng);
                idle_cycles(int'(rng % 8) + 1);    // gap of 1 to 8 cycles
                do_run(i);
            end
            idle_cycles(4);
        end else begin
            errors++;
            $display("could not read any run from dv/dm_vectors.txt");
        end
        $display("summary: %0d runs, %0d checks, %0d errors", kind_q.size(), checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog sized from the vector lengths
    initial begin
        wait (budget_ready);
        repeat (budget) @(posedge clk_80);
        $display("timeout after %0d cycles, a run never finished", budget);
        $display("Test failed");
        $finish;
    end

endmodule

/* dv/dm_vectors.txt */
# kind: 0 host start, 1 gpio start, 2 host start with a second edge while busy, 3 host and gpio
# columns: kind length(dec) start_addr(hex) expected_errors(dec)
0 1   00000000 0
0 16  00000100 0
0 256 12345678 0
1 37  deadbeef 0
0 0   00000040 0
0 300 00000000 44
0 511 fffffff0 255
2 64  00000080 0
3 200 00000010 0
0 257 80000000 1
1 511 00000000 0
0 100 3000ff00 0
2 0   00000020 0

/* verilog.f */
+incdir+include
hw/dm_test_pkg.sv
hw/wb_bus_pkg.sv
hw/dm_pattern_writer.sv
hw/dm_mem_buffer.sv
hw/dm_readback_checker.sv
hw/dm_test_top.sv
dv/dm_test_tb.sv

/* Makefile */
# Verilator flow for the data-mover validation testbench

VERILATOR ?= verilator
TOP       ?= dm_test_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ns
PASS_MSG  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
